//--- design/byte_field_reg.sv
`timescale 1ns/1ps

module byte_field_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear_i,
  input  logic       shift_i,
  input  logic [7:0] byte_i,
  output payload_t   field_o
);

  localparam int W = $bits(payload_t);

  logic [W-1:0] shifted;

  // older bytes move up, so the first byte ends as the msb
  assign shifted = {field_o[W-9:0], byte_i};

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      field_o <= '0;
    end else if (shift_i) begin
      field_o <= payload_t'(shifted);
    end
  end

endmodule

//--- design/control_block_parser.sv
`timescale 1ns/1ps
`include "sd_test_settings.svh"

module control_block_parser (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear_i,
  input  logic                 byte_valid_i,
  input  logic [9:0]           offset_i,
  input  logic [7:0]           byte_i,
  output logic                 sig_ok_o,
  output logic [31:0]          next_block_o,
  output sd_test_pkg::bytes_t  total_bytes_o,
  output sd_test_pkg::result_t expect_o
);

  import sd_test_pkg::*;

  logic [31:0] sig;
  logic        sig_hit;
  logic        next_hit;
  logic        total_hit;
  logic        expect_hit;

  function automatic logic covers(input logic [9:0] ofs, input int base, input int len);
    return (int'(ofs) >= base) && (int'(ofs) < base + len);
  endfunction

  //////////////////////////////////////////////////
  // field decode
  //////////////////////////////////////////////////
  assign sig_hit    = byte_valid_i && covers(offset_i, `OFS_SIG, `OFS_NEXT - `OFS_SIG);
  assign next_hit   = byte_valid_i && covers(offset_i, `OFS_NEXT, `OFS_TOTAL - `OFS_NEXT);
  assign total_hit  = byte_valid_i && covers(offset_i, `OFS_TOTAL, `OFS_EXPECT - `OFS_TOTAL);
  assign expect_hit = byte_valid_i && covers(offset_i, `OFS_EXPECT, `RESULT_BYTES);

  byte_field_reg #(.payload_t(logic [31:0])) u_sig_reg (
    .clk(clk), .rst(rst), .clear_i(clear_i), .shift_i(sig_hit),
    .byte_i(byte_i), .field_o(sig)
  );

  byte_field_reg #(.payload_t(logic [31:0])) u_next_reg (
    .clk(clk), .rst(rst), .clear_i(clear_i), .shift_i(next_hit),
    .byte_i(byte_i), .field_o(next_block_o)
  );

  byte_field_reg #(.payload_t(bytes_t)) u_total_reg (
    .clk(clk), .rst(rst), .clear_i(clear_i), .shift_i(total_hit),
    .byte_i(byte_i), .field_o(total_bytes_o)
  );

  byte_field_reg #(.payload_t(result_t)) u_expect_reg (
    .clk(clk), .rst(rst), .clear_i(clear_i), .shift_i(expect_hit),
    .byte_i(byte_i), .field_o(expect_o)
  );

  assign sig_ok_o = (sig == `SD_SIGNATURE);

endmodule

//--- design/report_serializer.sv
`timescale 1ns/1ps
`include "sd_test_settings.svh"

module report_serializer (
  input  logic [9:0]           offset_i,
  input  logic [31:0]          sig_i,
  input  logic [31:0]          next_block_i,
  input  sd_test_pkg::bytes_t  total_bytes_i,
  input  sd_test_pkg::result_t expect_i,
  input  sd_test_pkg::result_t result_i,
  input  sd_test_pkg::cycles_t cycles_i,
  output logic [7:0]           data_o
);

  // byte k of a len-byte field, msb first
  function automatic logic [7:0] pick(input logic [63:0] field, input int len, input int k);
    return 8'(field >> (8 * (len - 1 - k)));
  endfunction

  always_comb begin
    int ofs;
    ofs = int'(offset_i);
    data_o = 8'hFF;
    if (ofs >= `OFS_SIG && ofs < `OFS_NEXT) begin
      data_o = pick(64'(sig_i), `OFS_NEXT - `OFS_SIG, ofs - `OFS_SIG);
    end else if (ofs >= `OFS_NEXT && ofs < `OFS_TOTAL) begin
      data_o = pick(64'(next_block_i), `OFS_TOTAL - `OFS_NEXT, ofs - `OFS_NEXT);
    end else if (ofs >= `OFS_TOTAL && ofs < `OFS_EXPECT) begin
      data_o = pick(64'(total_bytes_i), `OFS_EXPECT - `OFS_TOTAL, ofs - `OFS_TOTAL);
    end else if (ofs >= `OFS_EXPECT && ofs < `OFS_RESULT) begin
      data_o = pick(64'(expect_i), `OFS_RESULT - `OFS_EXPECT, ofs - `OFS_EXPECT);
    end else if (ofs >= `OFS_RESULT && ofs < `OFS_CYCLES) begin
      data_o = pick(64'(result_i), `OFS_CYCLES - `OFS_RESULT, ofs - `OFS_RESULT);
    end else if (ofs >= `OFS_CYCLES && ofs < `OFS_REPORT_END) begin
      data_o = pick(64'(cycles_i), `OFS_REPORT_END - `OFS_CYCLES, ofs - `OFS_CYCLES);
    end
  end

endmodule

//--- design/sd_test_harness.sv
`timescale 1ns/1ps
`include "sd_test_settings.svh"

module sd_test_harness (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  output sd_test_pkg::sd_cmd_t   sd_cmd_o,
  input  sd_test_pkg::sd_stat_t  sd_stat_i,
  output sd_test_pkg::uut_ctrl_t uut_ctrl_o,
  input  sd_test_pkg::uut_stat_t uut_stat_i,
  output logic [31:0]            error_count_o
);

  import sd_test_pkg::*;

  logic        sig_ok;
  logic [31:0] next_block;
  bytes_t      total_bytes;
  result_t     expect_val;
  result_t     result;
  cycles_t     cycles;
  feed_word_t  feed_word;
  uut_ctrl_t   seq_ctrl;
  logic [9:0]  offset;
  logic [7:0]  wr_data;
  logic        byte_valid, clear, feed_shift;

  control_block_parser u_parser (
    .clk(clk), .rst(rst), .clear_i(clear), .byte_valid_i(byte_valid),
    .offset_i(offset), .byte_i(sd_stat_i.rd_data), .sig_ok_o(sig_ok),
    .next_block_o(next_block), .total_bytes_o(total_bytes), .expect_o(expect_val)
  );

  // feed word assembled straight from the multi-block read
  byte_field_reg #(.payload_t(feed_word_t)) u_feed_reg (
    .clk(clk), .rst(rst), .clear_i(1'b0), .shift_i(feed_shift),
    .byte_i(sd_stat_i.rd_data), .field_o(feed_word)
  );

  report_serializer u_serializer (
    .offset_i(offset), .sig_i(`SD_SIGNATURE), .next_block_i(next_block),
    .total_bytes_i(total_bytes), .expect_i(expect_val), .result_i(result),
    .cycles_i(cycles), .data_o(wr_data)
  );

  test_sequencer u_sequencer (
    .clk(clk), .rst(rst), .start_i(start_i), .sd_stat_i(sd_stat_i), .sig_ok_i(sig_ok),
    .total_bytes_i(total_bytes), .next_block_i(next_block), .expect_i(expect_val),
    .uut_stat_i(uut_stat_i), .wr_data_i(wr_data), .sd_cmd_o(sd_cmd_o), .offset_o(offset),
    .byte_valid_o(byte_valid), .clear_o(clear), .feed_shift_o(feed_shift),
    .uut_ctrl_o(seq_ctrl), .result_o(result), .cycles_o(cycles),
    .error_count_o(error_count_o)
  );

  always_comb begin
    uut_ctrl_o           = seq_ctrl;
    uut_ctrl_o.feed_data = feed_word;
  end

endmodule

//--- design/sd_test_pkg.sv
`include "sd_test_settings.svh"

package sd_test_pkg;

  typedef logic [`FEED_BYTES*8-1:0]   feed_word_t;
  typedef logic [`RESULT_BYTES*8-1:0] result_t;
  typedef logic [63:0]                cycles_t;
  typedef logic [63:0]                bytes_t;

  // requests towards the sd host, all held at level
  typedef struct packed {
    logic        host_rst;
    logic        rd_block;
    logic        rd_multi;
    logic        rd_byte;
    logic        wr_block;
    logic        wr_byte;
    logic [31:0] block_addr;
    logic [7:0]  wr_data;
  } sd_cmd_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] rd_data;
  } sd_stat_t;

  typedef struct packed {
    logic       rst;
    logic       feed;
    logic       stop;
    feed_word_t feed_data;
  } uut_ctrl_t;

  typedef struct packed {
    logic    busy;
    logic    done;
    logic    err;
    result_t result;
  } uut_stat_t;

  typedef enum logic [3:0] {
    S_IDLE, S_HOST_RST, S_CTRL_READ, S_SIG_CHECK, S_MULTI_OPEN, S_FEED_READ, S_FEED,
    S_UUT_WAIT, S_STOP, S_DONE_WAIT, S_COMPARE, S_WR_OPEN, S_WR_BYTES, S_ADVANCE
  } seq_state_t;

endpackage

//--- design/sd_test_settings.svh
`ifndef SD_TEST_SETTINGS_SVH
`define SD_TEST_SETTINGS_SVH

// sd card geometry
`define SD_BLOCK_BYTES 512
`define SD_START_BLOCK 32'h100000
`define SD_SIGNATURE   32'hAABBCCDD

// uut payload widths in bytes
`define FEED_BYTES   4
`define RESULT_BYTES 4

// control block layout, big-endian fields
`define OFS_SIG        0
`define OFS_NEXT       4
`define OFS_TOTAL      8
`define OFS_EXPECT     16
// report additions after the echoed fields
`define OFS_RESULT     20
`define OFS_CYCLES     24
`define OFS_REPORT_END 32

`endif

//--- design/test_sequencer.sv
`timescale 1ns/1ps
`include "sd_test_settings.svh"

module test_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  sd_test_pkg::sd_stat_t  sd_stat_i,
  input  logic                   sig_ok_i,
  input  sd_test_pkg::bytes_t    total_bytes_i,
  input  logic [31:0]            next_block_i,
  input  sd_test_pkg::result_t   expect_i,
  input  sd_test_pkg::uut_stat_t uut_stat_i,
  input  logic [7:0]             wr_data_i,
  output sd_test_pkg::sd_cmd_t   sd_cmd_o,
  output logic [9:0]             offset_o,
  output logic                   byte_valid_o,
  output logic                   clear_o,
  output logic                   feed_shift_o,
  output sd_test_pkg::uut_ctrl_t uut_ctrl_o,
  output sd_test_pkg::result_t   result_o,
  output sd_test_pkg::cycles_t   cycles_o,
  output logic [31:0]            error_count_o
);

  import sd_test_pkg::*;

  localparam logic [9:0] LAST_BYTE = 10'(`SD_BLOCK_BYTES - 1);
  localparam logic [9:0] WORD_LAST = 10'(`FEED_BYTES - 1);

  seq_state_t  state;
  logic        phase;
  logic        opened;
  logic        uut_rst;
  logic        done_seen;
  logic        err_seen;
  logic [9:0]  offset;
  logic [31:0] cur_block;
  bytes_t      feed_cnt;
  logic        hs_take, hs_done, u_take, u_done, feed_done, finished;

  // phase marks that busy was seen high in the current handshake
  assign hs_take   = !phase && sd_stat_i.busy;
  assign hs_done   = phase && !sd_stat_i.busy;
  assign u_take    = !phase && uut_stat_i.busy;
  assign u_done    = phase && !uut_stat_i.busy;
  assign feed_done = (feed_cnt >= total_bytes_i);
  assign finished  = done_seen || uut_stat_i.done || uut_stat_i.err;
  assign offset_o  = offset;

  //////////////////////////////////////////////////
  // main fsm
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= S_IDLE;
      phase         <= 1'b0;
      opened        <= 1'b0;
      uut_rst       <= 1'b1;
      offset        <= '0;
      cur_block     <= `SD_START_BLOCK;
      feed_cnt      <= '0;
      error_count_o <= '0;
    end else begin
      if (hs_take && state != S_FEED && state != S_UUT_WAIT) phase <= 1'b1;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            cur_block     <= `SD_START_BLOCK;
            error_count_o <= '0;
            state         <= S_HOST_RST;
          end
        end
        S_HOST_RST: begin
          if (hs_done) begin
            phase  <= 1'b0;
            opened <= 1'b0;
            offset <= '0;
            state  <= S_CTRL_READ;
          end
        end
        S_CTRL_READ: begin
          if (hs_done) begin
            phase <= 1'b0;
            if (!opened) begin
              opened <= 1'b1;
            end else if (offset == LAST_BYTE) begin
              offset <= '0;
              opened <= 1'b0;
              state  <= S_SIG_CHECK;
            end else begin
              offset <= offset + 1'b1;
            end
          end
        end
        S_SIG_CHECK: begin
          if (sig_ok_i) begin
            uut_rst  <= 1'b0;
            feed_cnt <= '0;
            state    <= S_MULTI_OPEN;
          end else begin
            state <= S_IDLE;
          end
        end
        S_MULTI_OPEN: begin
          if (hs_done) begin
            phase <= 1'b0;
            state <= feed_done ? S_STOP : S_FEED_READ;
          end
        end
        S_FEED_READ: begin
          if (hs_done) begin
            phase    <= 1'b0;
            feed_cnt <= feed_cnt + 1'b1;
            if (offset == WORD_LAST) begin
              offset <= '0;
              state  <= S_FEED;
            end else begin
              offset <= offset + 1'b1;
            end
          end
        end
        // one settle cycle so the word is stable before the pulse
        S_FEED: begin
          if (!phase) begin
            phase <= 1'b1;
          end else if (!uut_stat_i.busy) begin
            phase <= 1'b0;
            state <= S_UUT_WAIT;
          end
        end
        S_UUT_WAIT: begin
          if (u_take) phase <= 1'b1;
          if (u_done) begin
            phase <= 1'b0;
            state <= feed_done ? S_STOP : S_FEED_READ;
          end
        end
        S_STOP: state <= S_DONE_WAIT;
        S_DONE_WAIT: begin
          if (finished) begin
            result_o <= uut_stat_i.result;
            state    <= S_COMPARE;
          end
        end
        S_COMPARE: begin
          if (err_seen || result_o != expect_i) error_count_o <= error_count_o + 1'b1;
          offset <= '0;
          state  <= S_WR_OPEN;
        end
        S_WR_OPEN: begin
          if (hs_done) begin
            phase <= 1'b0;
            state <= S_WR_BYTES;
          end
        end
        S_WR_BYTES: begin
          if (hs_done) begin
            phase <= 1'b0;
            if (offset == LAST_BYTE) begin
              offset  <= '0;
              uut_rst <= 1'b1;
              state   <= S_ADVANCE;
            end else begin
              offset <= offset + 1'b1;
            end
          end
        end
        S_ADVANCE: begin
          cur_block <= next_block_i;
          opened    <= 1'b0;
          state     <= S_CTRL_READ;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // execution cycles, frozen once done or err shows up
  always_ff @(posedge clk) begin
    if (rst || uut_rst) begin
      cycles_o  <= '0;
      done_seen <= 1'b0;
      err_seen  <= 1'b0;
    end else if (!done_seen) begin
      if (uut_stat_i.done || uut_stat_i.err) begin
        done_seen <= 1'b1;
        err_seen  <= uut_stat_i.err;
      end else begin
        cycles_o <= cycles_o + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // request and strobe decode
  //////////////////////////////////////////////////
  always_comb begin
    sd_cmd_o     = '0;
    uut_ctrl_o   = '0;
    byte_valid_o = 1'b0;
    clear_o      = 1'b0;
    feed_shift_o = 1'b0;
    case (state)
      S_HOST_RST: sd_cmd_o.host_rst = !phase;
      S_CTRL_READ: begin
        sd_cmd_o.rd_block = 1'b1;
        sd_cmd_o.rd_byte  = opened && !phase;
        clear_o           = !opened;
        byte_valid_o      = opened && hs_done;
      end
      S_MULTI_OPEN: sd_cmd_o.rd_multi = 1'b1;
      S_FEED_READ: begin
        sd_cmd_o.rd_multi = 1'b1;
        sd_cmd_o.rd_byte  = !phase;
        feed_shift_o      = hs_done;
      end
      S_FEED: begin
        sd_cmd_o.rd_multi = 1'b1;
        uut_ctrl_o.feed   = phase && !uut_stat_i.busy;
      end
      S_UUT_WAIT: sd_cmd_o.rd_multi = 1'b1;
      S_STOP: uut_ctrl_o.stop = 1'b1;
      S_WR_OPEN: sd_cmd_o.wr_block = 1'b1;
      S_WR_BYTES: begin
        sd_cmd_o.wr_block = 1'b1;
        sd_cmd_o.wr_byte  = !phase;
      end
      default: ;
    endcase
    // feed data lives one block past the control block
    sd_cmd_o.block_addr = sd_cmd_o.rd_multi ? cur_block + 32'd1 : cur_block;
    sd_cmd_o.wr_data    = wr_data_i;
    uut_ctrl_o.rst      = uut_rst;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sd_test_harness.f \
  --top-module sd_test_harness_tb -o sd_test_harness_sim

output="$(./obj_dir/sd_test_harness_sim 2>&1 || true)"
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- sd_test_harness.f
+incdir+design
design/sd_test_pkg.sv
design/byte_field_reg.sv
design/control_block_parser.sv
design/report_serializer.sv
design/test_sequencer.sv
design/sd_test_harness.sv
verif/sd_test_harness_tb.sv

//--- verif/sd_test_harness_tb.sv
`timescale 1ns/1ps
`include "sd_test_settings.svh"

module sd_test_harness_tb;

  import sd_test_pkg::*;

  localparam int BLK            = `SD_BLOCK_BYTES;
  localparam int TIMEOUT_CYCLES = 200 * `SD_BLOCK_BYTES * 6;
  localparam int N_TESTS        = 3;

  logic        clk;
  logic        rst;
  logic        start;
  sd_cmd_t     sd_cmd;
  sd_stat_t    sd_stat;
  uut_ctrl_t   uut_ctrl;
  uut_stat_t   uut_stat;
  logic [31:0] error_count;

  logic [15:0] lfsr;
  logic [7:0]  card [longint];
  logic [31:0] chain_addr [N_TESTS+1];
  logic [31:0] words [N_TESTS][8];
  int          n_words [N_TESTS];
  logic [31:0] expect_val [N_TESTS];
  logic [31:0] sum_val [N_TESTS];
  int          n_corrupt;
  int          cur_test;
  int          tests_done;
  logic        bad_seen;
  logic [63:0] mon_cycles;
  logic        mon_seen;
  int          cycle_cnt = 0;

  sd_test_harness UUT (
    .clk(clk), .rst(rst), .start_i(start), .sd_cmd_o(sd_cmd), .sd_stat_i(sd_stat),
    .uut_ctrl_o(uut_ctrl), .uut_stat_i(uut_stat), .error_count_o(error_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want));
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic longint key(input logic [31:0] blk, input int ofs);
    return longint'(blk) * BLK + longint'(ofs);
  endfunction

  task automatic fill_block(input logic [31:0] blk);
    int     k;
    longint a;
    for (k = 0; k < BLK; k++) begin
      a = key(blk, k);
      card[a] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32];
    end
  endtask

  // big-endian field store
  task automatic put_field(input logic [31:0] blk, input int ofs, input int len,
                           input logic [63:0] val);
    int k;
    for (k = 0; k < len; k++) begin
      card[key(blk, ofs + k)] = 8'(val >> (8 * (len - 1 - k)));
    end
  endtask

  task automatic build_card();
    int          t;
    int          w;
    logic [31:0] sum;
    logic [31:0] r;
    for (t = 0; t <= N_TESTS; t++) begin
      chain_addr[t] = `SD_START_BLOCK + 32'(t * 24);
    end
    for (t = 0; t < N_TESTS; t++) begin
      n_words[t] = 2 + int'(rand_bits(3)) % 5;
      fill_block(chain_addr[t]);
      fill_block(chain_addr[t] + 1);
      sum = '0;
      for (w = 0; w < n_words[t]; w++) begin
        words[t][w] = rand_bits(32);
        sum = sum + words[t][w];
        put_field(chain_addr[t] + 1, w * `FEED_BYTES, `FEED_BYTES, 64'(words[t][w]));
      end
      sum_val[t]    = sum;
      expect_val[t] = sum;
      r = rand_bits(1);
      // first test always clean, second always corrupted
      if (t != 0 && (r[0] || t == 1)) begin
        expect_val[t] = sum ^ (rand_bits(8) | 32'h1);
        n_corrupt++;
      end
      put_field(chain_addr[t], `OFS_SIG, 4, `SD_SIGNATURE);
      put_field(chain_addr[t], `OFS_NEXT, 4, chain_addr[t+1]);
      put_field(chain_addr[t], `OFS_TOTAL, 8, 64'(n_words[t] * `FEED_BYTES));
      put_field(chain_addr[t], `OFS_EXPECT, `RESULT_BYTES, expect_val[t]);
    end
    // end of chain
    fill_block(chain_addr[N_TESTS]);
    put_field(chain_addr[N_TESTS], `OFS_SIG, 4, 64'h5A5A0F0F);
  endtask

  function automatic logic [7:0] report_byte(input int t, input int ofs);
    logic [255:0] img;
    img = {`SD_SIGNATURE, chain_addr[t+1], 64'(n_words[t] * `FEED_BYTES),
           expect_val[t], sum_val[t], mon_cycles};
    if (ofs < `OFS_REPORT_END) return img[255 - 8 * ofs -: 8];
    return 8'hFF;
  endfunction

  task automatic check_quiet();
    check("sd_cmd_o requests", {sd_cmd.host_rst, sd_cmd.rd_block, sd_cmd.rd_multi,
                                sd_cmd.rd_byte, sd_cmd.wr_block, sd_cmd.wr_byte}, 6'b0);
    check("uut_ctrl_o feed/stop", {uut_ctrl.feed, uut_ctrl.stop}, 2'b0);
    check("uut_ctrl_o.rst", uut_ctrl.rst, 1'b1);
  endtask

  task automatic serve_byte(input logic [7:0] data);
    logic [31:0] d;
    d = rand_bits(2);
    @(posedge clk);
    #1;
    sd_stat.busy = 1'b1;
    repeat (d + 1) @(posedge clk);
    #1;
    sd_stat.rd_data = data;
    sd_stat.busy    = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // sd card and host
  //////////////////////////////////////////////////
  initial begin : sd_host
    int          mode;
    int          pos;
    logic [31:0] open_addr;
    sd_stat.busy    = 1'b0;
    sd_stat.rd_data = 8'h00;
    mode      = 0;
    pos       = 0;
    open_addr = '0;
    // mode 0 idle, 1 block read, 2 multi read, 3 write
    forever begin
      @(negedge clk);
      if (rst) begin
        mode = 0;
      end else if (sd_cmd.host_rst) begin
        mode = 0;
        serve_byte(8'h00);
      end else if (mode == 0 && (sd_cmd.rd_multi || sd_cmd.wr_block) && cur_test >= N_TESTS) begin
        abort_run("feed read or report write after the bad signature block");
      end else if (mode == 0 && (sd_cmd.rd_block || sd_cmd.rd_multi || sd_cmd.wr_block)) begin
        check("sd_cmd_o.block_addr", sd_cmd.block_addr,
              sd_cmd.rd_multi ? chain_addr[cur_test] + 1 : chain_addr[cur_test]);
        open_addr = sd_cmd.block_addr;
        pos       = 0;
        mode      = sd_cmd.rd_block ? 1 : (sd_cmd.rd_multi ? 2 : 3);
        serve_byte(8'h00);
      end else if ((mode == 1 || mode == 2) && sd_cmd.rd_byte) begin
        pos = pos + 1;
        serve_byte(card[key(open_addr, pos - 1)]);
      end else if (mode == 3 && sd_cmd.wr_byte) begin
        check("sd_cmd_o.wr_data", sd_cmd.wr_data, report_byte(cur_test, pos));
        card[key(open_addr, pos)] = sd_cmd.wr_data;
        pos = pos + 1;
        serve_byte(8'h00);
      end else if (mode == 1 && !sd_cmd.rd_block) begin
        check("control block bytes read", pos, BLK);
        mode = 0;
        if (cur_test == N_TESTS) bad_seen = 1'b1;
      end else if (mode == 2 && !sd_cmd.rd_multi) begin
        check("feed bytes read", pos, n_words[cur_test] * `FEED_BYTES);
        mode = 0;
      end else if (mode == 3 && !sd_cmd.wr_block) begin
        check("report bytes written", pos, BLK);
        mode       = 0;
        cur_test   = cur_test + 1;
        tests_done = tests_done + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // uut model and cycle monitor
  //////////////////////////////////////////////////
  initial begin : uut_model
    int          fed;
    logic [31:0] acc;
    logic [31:0] d;
    uut_stat = '0;
    fed      = 0;
    acc      = '0;
    forever begin
      @(negedge clk);
      if (rst || uut_ctrl.rst) begin
        fed = 0;
        acc = '0;
        @(posedge clk);
        #1;
        uut_stat = '0;
      end else if ((uut_ctrl.feed || uut_ctrl.stop) && cur_test >= N_TESTS) begin
        abort_run("uut feed or stop after the bad signature block");
      end else if (uut_ctrl.feed) begin
        if (fed >= n_words[cur_test]) abort_run("feed pulse after the last stored word");
        check("uut_ctrl_o.feed_data", uut_ctrl.feed_data, words[cur_test][fed]);
        acc = acc + uut_ctrl.feed_data;
        fed = fed + 1;
        d = rand_bits(2);
        @(posedge clk);
        #1;
        uut_stat.busy   = 1'b1;
        uut_stat.result = acc;
        // no feed may arrive while busy is high
        repeat (d + 1) begin
          @(negedge clk);
          check("uut_ctrl_o.feed while busy", uut_ctrl.feed, 1'b0);
          @(posedge clk);
        end
        #1;
        uut_stat.busy = 1'b0;
      end else if (uut_ctrl.stop) begin
        check("words fed before stop", fed, n_words[cur_test]);
        d = rand_bits(2);
        repeat (d + 1) @(posedge clk);
        #1;
        uut_stat.done = 1'b1;
      end
    end
  end

  // values at the negedge are the ones the next rising edge sees
  always @(negedge clk) begin
    if (rst || uut_ctrl.rst) begin
      mon_cycles <= '0;
      mon_seen   <= 1'b0;
    end else if (!mon_seen) begin
      if (uut_stat.done || uut_stat.err) begin
        mon_seen <= 1'b1;
      end else begin
        mon_cycles <= mon_cycles + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: the test chain did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin : main_seq
    int run;
    lfsr       = 16'd51839;
    rst        = 1'b1;
    start      = 1'b0;
    n_corrupt  = 0;
    cur_test   = 0;
    tests_done = 0;
    bad_seen   = 1'b0;
    build_card();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_quiet();
      check("error_count_o", error_count, 0);
    end
    // the second pass reads the reports back as control blocks
    for (run = 0; run < 2; run++) begin
      cur_test   = 0;
      tests_done = 0;
      bad_seen   = 1'b0;
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      while (!bad_seen) @(negedge clk);
      repeat (20) begin
        @(negedge clk);
        check_quiet();
      end
      check("tests completed", tests_done, N_TESTS);
      check("error_count_o", error_count, n_corrupt);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
